/* flist.f */
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
test/mem_model.sv
test/dcache_tb.sv

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       cpu_valid,
    output logic                       cpu_ready,
    input  dcache_pkg::cpu_req_t       cpu_req,
    output dcache_pkg::cpu_resp_t      cpu_resp,
    output logic                       mem_valid,
    input  logic                       mem_ready,
    output dcache_pkg::mem_req_t       mem_req,
    input  dcache_pkg::mem_resp_t      mem_resp,
    output logic                       lookup_en,
    output logic [`DC_ADDR_W-1:0]      lookup_addr,
    input  dcache_pkg::lookup_result_t lookup,
    output dcache_pkg::tag_update_t    tag_update,
    output logic                       read_en,
    output logic                       read_way,
    output logic [`DC_SET_W-1:0]       read_set,
    input  logic [`DC_LINE_W-1:0]      rdata_line,
    output dcache_pkg::data_write_t    data_write
);

    dcache_pkg::cache_state_e   state;
    dcache_pkg::cache_state_e   next_state;
    dcache_pkg::cpu_req_t       req_q;
    dcache_pkg::lookup_result_t lk_q;

    logic                                  hit_phase;  // second cycle of READ_HIT
    logic                                  mem_sent;   // handshake done, waiting for done
    logic [`DC_LINE_W-1:0]                 fill_line;
    logic [`DC_LINE_W-1:0]                 merged_line;
    logic [`DC_LINE_W/8-1:0]               hit_strb;
    logic [`DC_OFFSET_W-`DC_BANK_LSB-1:0]  bank;
    logic [`DC_SET_W-1:0]                  req_set;
    logic [`DC_TAG_W-1:0]                  req_tag;
    logic                                  is_write;

    assign bank     = req_q.addr[`DC_OFFSET_W-1:`DC_BANK_LSB];
    assign req_set  = req_q.addr[`DC_OFFSET_W +: `DC_SET_W];
    assign req_tag  = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign is_write = (req_q.op == dcache_pkg::OP_WRITE);

    // accepted request is held for the whole transaction
    always_ff @(posedge clock) begin
        if (cpu_valid && cpu_ready)
            req_q <= cpu_req;
        if (state == dcache_pkg::LOOKUP)
            lk_q <= lookup;
        if (state == dcache_pkg::FETCH && mem_resp.done)
            fill_line <= mem_resp.data;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state     <= dcache_pkg::IDLE;
            hit_phase <= 1'b0;
            mem_sent  <= 1'b0;
        end else begin
            state     <= next_state;
            hit_phase <= (state == dcache_pkg::READ_HIT) && !hit_phase;
            if (mem_valid && mem_ready)
                mem_sent <= 1'b1;
            else if (mem_resp.done)
                mem_sent <= 1'b0;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::IDLE:        if (cpu_valid) next_state = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP: begin
                if (lookup.hit)
                    next_state = is_write ? dcache_pkg::WRITE_HIT : dcache_pkg::READ_HIT;
                else
                    next_state = lookup.victim_dirty ? dcache_pkg::READ_VICTIM
                                                     : dcache_pkg::FETCH;
            end
            dcache_pkg::WRITE_HIT:   next_state = dcache_pkg::IDLE;
            dcache_pkg::READ_HIT:    if (hit_phase) next_state = dcache_pkg::IDLE;
            dcache_pkg::READ_VICTIM: next_state = dcache_pkg::WRITE_BACK;
            dcache_pkg::WRITE_BACK:  if (mem_resp.done) next_state = dcache_pkg::FETCH;
            dcache_pkg::FETCH:       if (mem_resp.done) next_state = dcache_pkg::REFILL;
            dcache_pkg::REFILL:      next_state = dcache_pkg::IDLE;
            default:                 next_state = dcache_pkg::IDLE;
        endcase
    end

    // store word merged into the fetched line, plain line for loads
    always_comb begin
        merged_line = fill_line;
        hit_strb    = '0;
        hit_strb[bank*8 +: 8] = req_q.wstrb;
        if (is_write) begin
            for (int k = 0; k < 8; k++) begin
                if (req_q.wstrb[k])
                    merged_line[bank*`DC_WORD_W + k*8 +: 8] = req_q.wdata[k*8 +: 8];
            end
        end
    end

    assign lookup_en   = (state == dcache_pkg::IDLE) && cpu_valid;
    assign lookup_addr = cpu_req.addr;

    assign read_en  = (state == dcache_pkg::READ_HIT && !hit_phase) ||
                      (state == dcache_pkg::READ_VICTIM);
    assign read_way = (state == dcache_pkg::READ_VICTIM) ? lk_q.victim_way : lk_q.hit_way;
    assign read_set = req_set;

    always_comb begin
        tag_update.we    = (state == dcache_pkg::WRITE_HIT) || (state == dcache_pkg::REFILL);
        tag_update.way   = (state == dcache_pkg::REFILL) ? lk_q.victim_way : lk_q.hit_way;
        tag_update.set   = req_set;
        tag_update.tag   = req_tag;
        tag_update.dirty = is_write;  // a read refill leaves the line clean

        data_write.we    = tag_update.we;
        data_write.way   = tag_update.way;
        data_write.set   = req_set;
        if (state == dcache_pkg::REFILL) begin
            data_write.line = merged_line;
            data_write.strb = '1;
        end else begin
            data_write.line = {`DC_BANKS{req_q.wdata}};
            data_write.strb = hit_strb;
        end
    end

    assign cpu_ready     = (state == dcache_pkg::IDLE);
    assign cpu_resp.done = (state == dcache_pkg::WRITE_HIT) ||
                           (state == dcache_pkg::READ_HIT && hit_phase) ||
                           (state == dcache_pkg::REFILL);
    assign cpu_resp.rdata = (state == dcache_pkg::REFILL) ?
                            merged_line[bank*`DC_WORD_W +: `DC_WORD_W] :
                            rdata_line[bank*`DC_WORD_W +: `DC_WORD_W];

    assign mem_valid = ((state == dcache_pkg::WRITE_BACK) || (state == dcache_pkg::FETCH)) &&
                       !mem_sent;

    always_comb begin
        if (state == dcache_pkg::WRITE_BACK) begin
            mem_req.addr = {lk_q.victim_tag, req_set, {`DC_OFFSET_W{1'b0}}};
            mem_req.op   = dcache_pkg::OP_WRITE;
            mem_req.data = rdata_line;  // victim line, held since READ_VICTIM
        end else begin
            mem_req.addr = {req_tag, req_set, {`DC_OFFSET_W{1'b0}}};
            mem_req.op   = dcache_pkg::OP_READ;
            mem_req.data = '0;
        end
    end

    a_mem_req_stable: assert property (@(posedge clock) disable iff (!reset_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
        else $error("memory request dropped or changed before mem_ready");

    // done closes the transaction, the cache is idle right after it
    a_done_then_idle: assert property (@(posedge clock) disable iff (!reset_n)
        cpu_resp.done |=> state == dcache_pkg::IDLE)
        else $error("core done pulse not followed by idle");

endmodule

/* rtl/dcache_data_array.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_data_array (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    read_en,
    input  logic                    read_way,
    input  logic [`DC_SET_W-1:0]    read_set,
    output logic [`DC_LINE_W-1:0]   rdata_line,
    input  dcache_pkg::data_write_t data_write
);

    // entry index is {way, set}
    logic [`DC_SET_W:0] rd_idx;
    logic [`DC_SET_W:0] wr_idx;

    assign rd_idx = {read_way, read_set};
    assign wr_idx = {data_write.way, data_write.set};

    for (genvar b = 0; b < `DC_BANKS; b++) begin : g_bank
        logic [`DC_WORD_W-1:0] bank_mem [`DC_WAYS*`DC_SETS];
        logic [`DC_WORD_W-1:0] bank_q;
        logic [7:0]            byte_en;

        assign byte_en = data_write.strb[b*8 +: 8];

        always_ff @(posedge clock) begin
            if (data_write.we) begin
                for (int k = 0; k < 8; k++) begin
                    if (byte_en[k])
                        bank_mem[wr_idx][k*8 +: 8] <=
                            data_write.line[b*`DC_WORD_W + k*8 +: 8];
                end
            end
            if (read_en)
                bank_q <= bank_mem[rd_idx];  // held until the next read
        end

        assign rdata_line[b*`DC_WORD_W +: `DC_WORD_W] = bank_q;
    end

    // the controller never needs both ports in one cycle
    a_no_rw_overlap: assert property (@(posedge clock) disable iff (!reset_n)
        !(read_en && data_write.we))
        else $error("data array read and write in the same cycle");

endmodule

/* rtl/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// core address and data word
`define DC_ADDR_W    32
`define DC_WORD_W    64

// line layout, eight 64-bit banks per 64-byte line
`define DC_BANKS     8
`define DC_LINE_W    (`DC_WORD_W * `DC_BANKS)
`define DC_OFFSET_W  6
`define DC_BANK_LSB  3   // bits below this pick a byte inside the word

// set and way geometry
`define DC_SET_W     4
`define DC_SETS      (1 << `DC_SET_W)
`define DC_WAYS      2

// whatever is left above set and offset
`define DC_TAG_W     (`DC_ADDR_W - `DC_SET_W - `DC_OFFSET_W)

// replacement lfsr start value, must not be zero
`define DC_LFSR_SEED 8'hA5

`endif

/* rtl/dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_HIT,
        READ_HIT,
        READ_VICTIM,  // dirty victim line is read out here
        WRITE_BACK,
        FETCH,
        REFILL
    } cache_state_e;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cache_op_e;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        cache_op_e             op;
        logic [`DC_WORD_W-1:0] wdata;
        logic [7:0]            wstrb;  // one bit per byte of wdata
    } cpu_req_t;

    typedef struct packed {
        logic                  done;
        logic [`DC_WORD_W-1:0] rdata;
    } cpu_resp_t;

    // line aligned, data only meaningful for writes
    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        cache_op_e             op;
        logic [`DC_LINE_W-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic                  done;
        logic [`DC_LINE_W-1:0] data;
    } mem_resp_t;

    typedef struct packed {
        logic                 we;
        logic                 way;
        logic [`DC_SET_W-1:0] set;
        logic [`DC_TAG_W-1:0] tag;
        logic                 dirty;
    } tag_update_t;

    typedef struct packed {
        logic                 hit;
        logic                 hit_way;
        logic                 victim_way;
        logic                 victim_dirty;
        logic [`DC_TAG_W-1:0] victim_tag;
    } lookup_result_t;

    typedef struct packed {
        logic                    we;
        logic                    way;
        logic [`DC_SET_W-1:0]    set;
        logic [`DC_LINE_W-1:0]   line;
        logic [`DC_LINE_W/8-1:0] strb;  // byte enables over the whole line
    } data_write_t;

endpackage

/* rtl/dcache_tag_array.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tag_array (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       lookup_en,
    input  logic [`DC_ADDR_W-1:0]      lookup_addr,
    output dcache_pkg::lookup_result_t lookup,
    input  dcache_pkg::tag_update_t    tag_update
);

    logic [`DC_TAG_W-1:0]                tag_mem [`DC_WAYS][`DC_SETS];
    logic [`DC_WAYS-1:0][`DC_SETS-1:0]   valid_q;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0]   dirty_q;
    logic [7:0]                          lfsr;

    logic [`DC_SET_W-1:0]                lk_set;
    logic [`DC_TAG_W-1:0]                lk_tag;
    logic [`DC_WAYS-1:0]                 way_hit;
    logic [`DC_WAYS-1:0]                 way_valid;
    logic [`DC_WAYS-1:0]                 way_dirty;
    logic                                victim;

    assign lk_set = lookup_addr[`DC_OFFSET_W +: `DC_SET_W];
    assign lk_tag = lookup_addr[`DC_ADDR_W-1 -: `DC_TAG_W];

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_valid[w] = valid_q[w][lk_set];
            way_dirty[w] = dirty_q[w][lk_set];
            way_hit[w]   = way_valid[w] && (tag_mem[w][lk_set] == lk_tag);
        end
        // empty way first, random pick once the set is full
        if (!way_valid[0])
            victim = 1'b0;
        else if (!way_valid[1])
            victim = 1'b1;
        else
            victim = lfsr[0];
    end

    // x^8 + x^6 + x^5 + x^4 + 1, free running
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n)
            lfsr <= `DC_LFSR_SEED;
        else
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lookup  <= '0;
        end else begin
            if (tag_update.we) begin
                valid_q[tag_update.way][tag_update.set] <= 1'b1;
                dirty_q[tag_update.way][tag_update.set] <= tag_update.dirty;
            end
            if (lookup_en) begin
                lookup.hit          <= |way_hit;
                lookup.hit_way      <= way_hit[1];
                lookup.victim_way   <= victim;
                lookup.victim_dirty <= way_valid[victim] && way_dirty[victim];
                lookup.victim_tag   <= tag_mem[victim][lk_set];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (tag_update.we)
            tag_mem[tag_update.way][tag_update.set] <= tag_update.tag;
    end

    // a refill never installs a tag that the other way already holds
    a_single_hit: assert property (@(posedge clock) disable iff (!reset_n)
        lookup_en |-> !(&way_hit))
        else $error("address hit in both ways of set %0d", lk_set);

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top (
    input  logic                  clock,
    input  logic                  reset_n,

    // core side
    input  logic                  cpu_valid,
    output logic                  cpu_ready,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output dcache_pkg::cpu_resp_t cpu_resp,

    // memory side, whole lines
    output logic                  mem_valid,
    input  logic                  mem_ready,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_resp_t mem_resp
);

    logic                       lookup_en;
    logic [`DC_ADDR_W-1:0]      lookup_addr;
    dcache_pkg::lookup_result_t lookup;
    dcache_pkg::tag_update_t    tag_update;

    logic                       read_en;
    logic                       read_way;
    logic [`DC_SET_W-1:0]       read_set;
    logic [`DC_LINE_W-1:0]      rdata_line;
    dcache_pkg::data_write_t    data_write;

    dcache_ctrl u_ctrl (
        .clock       (clock),
        .reset_n     (reset_n),
        .cpu_valid   (cpu_valid),
        .cpu_ready   (cpu_ready),
        .cpu_req     (cpu_req),
        .cpu_resp    (cpu_resp),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .mem_req     (mem_req),
        .mem_resp    (mem_resp),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .lookup      (lookup),
        .tag_update  (tag_update),
        .read_en     (read_en),
        .read_way    (read_way),
        .read_set    (read_set),
        .rdata_line  (rdata_line),
        .data_write  (data_write)
    );

    dcache_tag_array u_tag_array (
        .clock       (clock),
        .reset_n     (reset_n),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .lookup      (lookup),
        .tag_update  (tag_update)
    );

    dcache_data_array u_data_array (
        .clock       (clock),
        .reset_n     (reset_n),
        .read_en     (read_en),
        .read_way    (read_way),
        .read_set    (read_set),
        .rdata_line  (rdata_line),
        .data_write  (data_write)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the dcache testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f flist.f -o dcache_sim

output="$(./obj_dir/dcache_sim 2>&1)" || true
echo "$output"

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

/* test/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tb;

    localparam int mem_words      = 2048;  // sixteen tags of 1 KiB
    localparam int clk_period     = 8;
    localparam int n_init         = 16;
    localparam int n_store        = 32;
    localparam int n_evict_rounds = 2;
    localparam int random_ops     = 2000;
    localparam int directed_ops   = 2 * n_init + 3 * n_store + 6 * n_evict_rounds;
    localparam int total_ops      = directed_ops + random_ops;

    logic                  clock = 1'b0;
    logic                  reset_n;
    logic                  cpu_valid;
    logic                  cpu_ready;
    dcache_pkg::cpu_req_t  cpu_req;
    dcache_pkg::cpu_resp_t cpu_resp;
    logic                  mem_valid;
    logic                  mem_ready;
    dcache_pkg::mem_req_t  mem_req;
    dcache_pkg::mem_resp_t mem_resp;

    logic [`DC_WORD_W-1:0] model_mem [mem_words];  // flat reference memory
    logic [`DC_WORD_W-1:0] rd_word;
    int                    latency;  // negedges from acceptance to done

    dcache_top dut0 (
        .clock     (clock),
        .reset_n   (reset_n),
        .cpu_valid (cpu_valid),
        .cpu_ready (cpu_ready),
        .cpu_req   (cpu_req),
        .cpu_resp  (cpu_resp),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp)
    );

    mem_model #(.words(mem_words)) u_mem (
        .clock     (clock),
        .reset_n   (reset_n),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp)
    );

    always #(clk_period / 2) clock = ~clock;

    function automatic logic [`DC_ADDR_W-1:0] word_addr(input int unsigned tag_n,
                                                        input int unsigned set_n,
                                                        input int unsigned bank_n);
        return (tag_n << (`DC_SET_W + `DC_OFFSET_W)) | (set_n << `DC_OFFSET_W) |
               (bank_n << `DC_BANK_LSB);
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // one core request, returns after cpu_ready is back
    task automatic access(input logic [`DC_ADDR_W-1:0] addr, input dcache_pkg::cache_op_e op,
                          input logic [63:0] wdata, input logic [7:0] wstrb);
        int dones;
        int cycles;
        @(posedge clock);
        cpu_valid     <= 1'b1;
        cpu_req.addr  <= addr;
        cpu_req.op    <= op;
        cpu_req.wdata <= wdata;
        cpu_req.wstrb <= wstrb;
        @(negedge clock);
        while (!cpu_ready)
            @(negedge clock);
        @(posedge clock);  // accepted here
        cpu_valid <= 1'b0;
        dones  = 0;
        cycles = 0;
        @(negedge clock);
        while (!cpu_ready) begin
            cycles++;
            if (cpu_resp.done) begin
                dones++;
                rd_word = cpu_resp.rdata;
                latency = cycles;
            end
            @(negedge clock);
        end
        check("one done per request", 64'(1), 64'(dones));
    endtask

    task automatic store(input logic [`DC_ADDR_W-1:0] addr, input logic [63:0] wdata,
                         input logic [7:0] wstrb);
        access(addr, dcache_pkg::OP_WRITE, wdata, wstrb);
        for (int k = 0; k < 8; k++) begin
            if (wstrb[k])
                model_mem[addr >> 3][k*8 +: 8] = wdata[k*8 +: 8];
        end
    endtask

    task automatic load_check(input string name, input logic [`DC_ADDR_W-1:0] addr);
        access(addr, dcache_pkg::OP_READ, 64'd0, 8'd0);
        check(name, model_mem[addr >> 3], rd_word);
    endtask

    initial begin
        logic [`DC_ADDR_W-1:0] a;
        int unsigned           s;
        int unsigned           b;
        void'($urandom(76771));
        reset_n   = 1'b1;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        for (int i = 0; i < mem_words; i++)
            model_mem[i] = {~32'(i * 8), 32'(i * 8)};
        #1 reset_n = 1'b0;  // async reset needs a real falling edge
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check("reset cpu_ready", 64'(1), 64'(cpu_ready));
        check("reset done", 64'(0), 64'(cpu_resp.done));
        check("reset mem_valid", 64'(0), 64'(mem_valid));

        // untouched lines, miss then hit
        for (int i = 0; i < n_init; i++) begin
            a = word_addr($urandom_range(15, 8), i, $urandom_range(7, 0));
            load_check("initial read miss", a);
            load_check("initial read hit", a);
            check("read hit latency", 64'(3), 64'(latency));
        end

        // strobed stores, first a miss then a hit
        for (int i = 0; i < n_store; i++) begin
            a = word_addr($urandom_range(7, 4), $urandom_range(15, 0), $urandom_range(7, 0));
            store(a, {$urandom, $urandom}, 8'($urandom));
            store(a, {$urandom, $urandom}, 8'($urandom));
            check("write hit latency", 64'(2), 64'(latency));
            load_check("store merge", a);
        end

        // three tags on two ways, dirty lines get evicted
        for (int r = 0; r < n_evict_rounds; r++) begin
            s = $urandom_range(15, 0);
            b = $urandom_range(7, 0);
            for (int t = 0; t < 3; t++)
                store(word_addr(12 + t, s, b), {$urandom, $urandom}, 8'hff);
            for (int t = 0; t < 3; t++)
                load_check("evict reread", word_addr(12 + t, s, b));
        end

        for (int i = 0; i < random_ops; i++) begin
            a = word_addr($urandom_range(3, 0), $urandom_range(15, 0), $urandom_range(7, 0));
            if ($urandom_range(1, 0) == 1)
                store(a, {$urandom, $urandom}, 8'($urandom));
            else
                load_check("random mix read", a);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

    // worst case miss with writeback stays well under 100 cycles
    initial begin
        #(total_ops * 100 * clk_period);
        $display("timeout: the cache stopped answering core requests");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* test/mem_model.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module mem_model #(
    parameter int words = 2048
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  mem_valid,
    output logic                  mem_ready,
    input  dcache_pkg::mem_req_t  mem_req,
    output dcache_pkg::mem_resp_t mem_resp
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_WAIT,  // request seen, ready delay running
        M_RESP   // accepted, done delay running
    } mem_phase_e;

    logic [`DC_WORD_W-1:0] mem [words];
    mem_phase_e            phase;
    logic [2:0]            wait_cnt;
    logic [`DC_ADDR_W-1:0] req_addr;

    // low half is the byte address, high half its inverse
    initial begin
        for (int i = 0; i < words; i++)
            mem[i] = {~32'(i * 8), 32'(i * 8)};
    end

    assign mem_ready = (phase == M_WAIT) && (wait_cnt == 3'd0);

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            phase    <= M_IDLE;
            wait_cnt <= 3'd0;
            req_addr <= '0;
            mem_resp <= '0;
        end else begin
            mem_resp.done <= 1'b0;  // single cycle pulse
            case (phase)
                M_IDLE: begin
                    if (mem_valid) begin
                        wait_cnt <= 3'($urandom_range(5, 0));
                        phase    <= M_WAIT;
                    end
                end
                M_WAIT: begin
                    if (wait_cnt != 3'd0) begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end else begin
                        // handshake happens on this edge
                        req_addr <= mem_req.addr;
                        if (mem_req.op == dcache_pkg::OP_WRITE) begin
                            for (int b = 0; b < `DC_BANKS; b++)
                                mem[(mem_req.addr >> 3) + b] <= mem_req.data[b*64 +: 64];
                        end
                        wait_cnt <= 3'($urandom_range(5, 0));
                        phase    <= M_RESP;
                    end
                end
                default: begin
                    if (wait_cnt != 3'd0) begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end else begin
                        mem_resp.done <= 1'b1;
                        for (int b = 0; b < `DC_BANKS; b++)
                            mem_resp.data[b*64 +: 64] <= mem[(req_addr >> 3) + b];
                        phase <= M_IDLE;
                    end
                end
            endcase
        end
    end

endmodule
